/* filelist.f */
src/adc_ctrl_pkg.sv
src/cmd_sequencer.sv
src/spi_frame_engine.sv
src/sample_packer.sv
src/ads_adc_ctrl.sv
test/adc_spi_model.sv
test/tb_ads_adc_ctrl.sv

/* src/adc_ctrl_pkg.sv */
package adc_ctrl_pkg;

  localparam int CMD_W       = 32;         // Command and data word width
  localparam int DELAY_W     = 25;         // Delay field and timer width
  localparam int SAMPLE_W    = 16;
  localparam int NUM_CH      = 8;
  localparam int READ_FRAMES = NUM_CH + 1; // Eight requests plus one trailing frame

  typedef logic [$clog2(NUM_CH)-1:0] chan_t;

  // Slot 0 sits in the low bits
  typedef chan_t [NUM_CH-1:0] sample_order_t;

  typedef enum logic [1:0] {
    NO_OP,
    ADC_READ,
    SET_ORDER,
    CANCEL
  } cmd_kind_e;

  // Wait view, used by no-op and ADC read
  typedef struct packed {
    cmd_kind_e                            kind;  // Bits 31:30
    logic                                 trig;  // Bit 29
    logic                                 cont;  // Bit 28, next command must follow
    logic [CMD_W-DELAY_W-5:0]             rsvd;
    logic [DELAY_W-1:0]                   delay; // Bits 24:0
  } cmd_wait_t;

  // Order view, used by set order
  typedef struct packed {
    cmd_kind_e                            kind;
    logic [CMD_W-$bits(sample_order_t)-3:0] rsvd;
    sample_order_t                        order; // Bits 23:0
  } cmd_order_t;

  typedef union packed {
    cmd_wait_t  wait_view;
    cmd_order_t order_view;
  } cmd_word_u;

  typedef logic [SAMPLE_W-1:0] sample_t;

  typedef struct packed {
    sample_t second; // High half
    sample_t first;  // Low half, earlier sample
  } data_word_t;

  typedef struct packed {
    logic unexp_trig;
    logic cmd_buf_underflow;
    logic data_buf_overflow;
  } err_flags_t;

  // Chip-select high time in clk cycles, max of conversion time and cycle time minus 16 bits
  function automatic int cs_high_cycles(input int model_id);
    case (model_id)
      8:       return 34;  // ADS8168
      7:       return 84;  // ADS8167
      default: return 184; // ADS8166 and anything unknown, slowest part
    endcase
  endfunction

  // On-the-fly request: 2'b10, channel, then zeros
  function automatic sample_t otf_sample_request(input chan_t ch);
    return {2'b10, ch, {(SAMPLE_W - 2 - $bits(chan_t)){1'b0}}};
  endfunction

endpackage

/* src/ads_adc_ctrl.sv */
module ads_adc_ctrl #(
  parameter int ADS_MODEL_ID = 8 // 8, 7 or 6 for ADS8168, ADS8167, ADS8166
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  adc_ctrl_pkg::cmd_word_u  cmd_word,
  input  logic                     cmd_buf_empty,
  output logic                     cmd_word_rd_en,
  output adc_ctrl_pkg::data_word_t data_word,
  output logic                     data_word_wr_en,
  input  logic                     data_buf_full,
  input  logic                     trigger,
  output logic                     waiting_for_trig,
  output adc_ctrl_pkg::err_flags_t flags,
  output logic                     n_cs,
  output logic                     mosi,
  input  logic                     miso
);

  localparam int CS_HIGH_CYCLES = adc_ctrl_pkg::cs_high_cycles(ADS_MODEL_ID);

  logic                  frame_start;
  logic                  frame_done;
  adc_ctrl_pkg::chan_t   req_chan;
  logic                  req_valid;
  logic                  capture;
  logic                  halt;      // Error state, stops engine and packer
  logic                  overflow;
  logic                  sample_valid;
  adc_ctrl_pkg::sample_t sample;

  cmd_sequencer u_seq (
    .clk, .resetn, .cmd_word, .cmd_buf_empty, .cmd_word_rd_en, .trigger, .waiting_for_trig,
    .frame_start, .req_chan, .req_valid, .capture, .frame_done, .overflow, .halt, .flags
  );

  spi_frame_engine #(.CS_HIGH_CYCLES(CS_HIGH_CYCLES)) u_spi (
    .clk, .resetn, .halt, .frame_start, .req_chan, .req_valid, .capture, .frame_done,
    .n_cs, .mosi, .miso, .sample_valid, .sample
  );

  sample_packer u_pack (
    .clk, .resetn, .halt, .sample_valid, .sample, .data_buf_full, .data_word,
    .data_word_wr_en, .overflow
  );

endmodule

/* src/cmd_sequencer.sv */
module cmd_sequencer (
  input  logic                     clk,
  input  logic                     resetn,
  input  adc_ctrl_pkg::cmd_word_u  cmd_word,
  input  logic                     cmd_buf_empty,
  output logic                     cmd_word_rd_en,
  input  logic                     trigger,
  output logic                     waiting_for_trig,
  output logic                     frame_start,
  output adc_ctrl_pkg::chan_t      req_chan,
  output logic                     req_valid,
  output logic                     capture,
  input  logic                     frame_done,
  input  logic                     overflow,
  output logic                     halt,
  output adc_ctrl_pkg::err_flags_t flags
);

  localparam int IDX_W = $clog2(adc_ctrl_pkg::READ_FRAMES);
  localparam int CH_W  = $bits(adc_ctrl_pkg::chan_t);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DELAY,
    ST_TRIG_WAIT,
    ST_READ,
    ST_ERROR
  } state_e;

  state_e                           state;
  state_e                           next_state;    // State for the incoming command
  adc_ctrl_pkg::cmd_kind_e          kind;
  logic                             cmd_done;      // Running command finished
  logic                             next_cmd;      // Finished and a new word is ready
  logic                             cancel_wait;
  logic                             new_read;
  logic [adc_ctrl_pkg::DELAY_W-1:0] delay_timer;
  logic                             wait_trig;     // Trig bit of the running command
  logic                             expect_next;   // Cont bit of the running command
  adc_ctrl_pkg::sample_order_t      order;
  logic [IDX_W-1:0]                 frame_idx;     // Frame in flight
  logic [IDX_W-1:0]                 next_idx;
  logic                             last_frame;
  logic                             rd_done;
  logic                             trig_err;
  logic                             underflow_err;
  logic                             err_event;

  assign kind             = cmd_word.wait_view.kind; // Same bits in both views
  assign halt             = (state == ST_ERROR);
  assign waiting_for_trig = (state == ST_TRIG_WAIT);

  assign last_frame = (frame_idx == IDX_W'(adc_ctrl_pkg::READ_FRAMES - 1));
  assign rd_done    = (state == ST_READ) && frame_done && last_frame;

  // Cancel only ends a wait, never a running read
  assign cancel_wait = ((state == ST_DELAY) || (state == ST_TRIG_WAIT) || rd_done)
                       && !cmd_buf_empty && (kind == adc_ctrl_pkg::CANCEL);

  assign cmd_done = ((state == ST_IDLE) && !cmd_buf_empty)
                    || ((state == ST_DELAY) && (delay_timer == '0))
                    || ((state == ST_TRIG_WAIT) && trigger)
                    || (rd_done && !wait_trig && (delay_timer == '0)); // Delay already ran out
  assign next_cmd = cmd_done && !cmd_buf_empty;
  assign new_read = next_cmd && (kind == adc_ctrl_pkg::ADC_READ);

  // Flag sources
  assign trig_err      = trigger && (state != ST_TRIG_WAIT) && !halt;
  assign underflow_err = cmd_done && expect_next && cmd_buf_empty;
  assign err_event     = trig_err || underflow_err || overflow;

  assign cmd_word_rd_en = !halt && !err_event && (next_cmd || cancel_wait);

  always_comb begin
    next_state = ST_IDLE; // Empty buffer, or set order / cancel done at once
    if (!cmd_buf_empty) begin
      case (kind)
        adc_ctrl_pkg::NO_OP:    next_state = cmd_word.wait_view.trig ? ST_TRIG_WAIT : ST_DELAY;
        adc_ctrl_pkg::ADC_READ: next_state = ST_READ;
        default:                next_state = ST_IDLE;
      endcase
    end
  end

  // Next frame request goes out in the cycle the last one ends
  assign frame_start = !err_event && (new_read || ((state == ST_READ) && frame_done && !last_frame));
  assign next_idx    = new_read ? '0 : frame_idx + 1'b1;
  assign req_chan    = order[next_idx[CH_W-1:0]];
  assign req_valid   = (next_idx < IDX_W'(adc_ctrl_pkg::NUM_CH)); // Trailing frame carries none
  assign capture     = (next_idx != '0);                          // Frame 0 returns nothing yet

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= ST_IDLE;
    end else if (err_event) begin
      state <= ST_ERROR; // Held until reset
    end else if (!halt) begin
      if (cancel_wait) state <= ST_IDLE;
      else if (cmd_done) state <= next_state;
      else if (rd_done) state <= wait_trig ? ST_TRIG_WAIT : ST_DELAY; // Rest of the wait
    end
  end

  // Sticky flags
  always_ff @(posedge clk) begin
    if (!resetn) begin
      flags <= '0;
    end else begin
      flags.unexp_trig        <= flags.unexp_trig | trig_err;
      flags.cmd_buf_underflow <= flags.cmd_buf_underflow | underflow_err;
      flags.data_buf_overflow <= flags.data_buf_overflow | overflow;
    end
  end

  // The delay timer runs alongside a read
  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
      delay_timer <= '0;
    end else begin
      if (next_cmd && ((kind == adc_ctrl_pkg::NO_OP) || (kind == adc_ctrl_pkg::ADC_READ))) begin
        wait_trig   <= cmd_word.wait_view.trig;
        expect_next <= cmd_word.wait_view.cont;
      end
      if (next_cmd && !cmd_word.wait_view.trig
          && ((kind == adc_ctrl_pkg::NO_OP) || (kind == adc_ctrl_pkg::ADC_READ)))
        delay_timer <= cmd_word.wait_view.delay;
      else if (cancel_wait) delay_timer <= '0;
      else if (delay_timer != '0) delay_timer <= delay_timer - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < adc_ctrl_pkg::NUM_CH; i++) order[i] <= CH_W'(i); // Identity order
    end else if (next_cmd && (kind == adc_ctrl_pkg::SET_ORDER)) begin
      order <= cmd_word.order_view.order;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || halt) frame_idx <= '0;
    else if (frame_start) frame_idx <= next_idx;
  end

  a_rd_en_not_empty : assert property (@(posedge clk) disable iff (!resetn)
    cmd_word_rd_en |-> !cmd_buf_empty);

  // The engine must answer before the next frame request
  a_one_frame : assert property (@(posedge clk) disable iff (!resetn || halt)
    frame_start |=> (!frame_start until frame_done));

endmodule

/* src/sample_packer.sv */
module sample_packer (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     halt,
  input  logic                     sample_valid,
  input  adc_ctrl_pkg::sample_t    sample,
  input  logic                     data_buf_full,
  output adc_ctrl_pkg::data_word_t data_word,
  output logic                     data_word_wr_en,
  output logic                     overflow
);

  adc_ctrl_pkg::sample_t first;      // First sample of the pair
  logic                  have_first; // Half-pair pending

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      have_first      <= 1'b0;
      data_word_wr_en <= 1'b0;
      overflow        <= 1'b0;
    end else begin
      data_word_wr_en <= 1'b0;
      overflow        <= 1'b0;
      if (sample_valid) begin
        have_first <= !have_first;
        if (have_first) begin
          data_word_wr_en <= !data_buf_full;
          overflow        <= data_buf_full; // No stall, the pair is dropped
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample_valid) begin
      if (have_first) begin
        data_word.second <= sample;
        data_word.first  <= first; // Earlier sample in the low half
      end else begin
        first <= sample;
      end
    end
  end

endmodule

/* src/spi_frame_engine.sv */
module spi_frame_engine #(
  parameter int CS_HIGH_CYCLES = 34
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  halt,
  input  logic                  frame_start,
  input  adc_ctrl_pkg::chan_t   req_chan,
  input  logic                  req_valid,
  input  logic                  capture,
  output logic                  frame_done,
  output logic                  n_cs,
  output logic                  mosi,
  input  logic                  miso,
  output logic                  sample_valid,
  output adc_ctrl_pkg::sample_t sample
);

  localparam int SW    = adc_ctrl_pkg::SAMPLE_W;
  localparam int CS_W  = $clog2(CS_HIGH_CYCLES);
  localparam int BIT_W = $clog2(SW);

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_CS_HIGH,
    ENG_SHIFT
  } eng_state_e;

  eng_state_e            state;
  logic [CS_W-1:0]       cs_cnt;   // Remaining chip-select high cycles
  logic [BIT_W-1:0]      bit_cnt;  // Remaining bits in the frame
  adc_ctrl_pkg::sample_t req_word; // Held until n_cs falls
  logic                  cap;      // This frame returns a sample
  logic [SW-1:0]         mosi_sr;
  logic [SW-2:0]         miso_sr;  // First 15 bits, last one taken straight from miso

  assign mosi = mosi_sr[SW-1]; // MSB first, register is zero while n_cs is high

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      state        <= ENG_IDLE;
      cs_cnt       <= '0;
      bit_cnt      <= '0;
      n_cs         <= 1'b1;
      mosi_sr      <= '0;
      miso_sr      <= '0;
      frame_done   <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      frame_done   <= 1'b0;
      sample_valid <= 1'b0;
      case (state)
        ENG_IDLE: begin
          if (frame_start) begin
            state  <= ENG_CS_HIGH;
            cs_cnt <= CS_W'(CS_HIGH_CYCLES - 2); // frame_done cycle and this one count too
          end
        end
        ENG_CS_HIGH: begin
          if (cs_cnt == '0) begin
            state   <= ENG_SHIFT;
            n_cs    <= 1'b0;
            mosi_sr <= req_word;
            bit_cnt <= BIT_W'(SW - 1);
          end else begin
            cs_cnt <= cs_cnt - 1'b1;
          end
        end
        ENG_SHIFT: begin
          miso_sr <= {miso_sr[SW-3:0], miso}; // Sample on every rising edge
          if (bit_cnt == '0) begin
            state        <= ENG_IDLE;
            n_cs         <= 1'b1;
            mosi_sr      <= '0;
            frame_done   <= 1'b1;
            sample_valid <= cap;
          end else begin
            mosi_sr <= {mosi_sr[SW-2:0], 1'b0};
            bit_cnt <= bit_cnt - 1'b1;
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (frame_start) begin
      req_word <= req_valid ? adc_ctrl_pkg::otf_sample_request(req_chan) : '0; // Zeros keep ADC idle
      cap      <= capture;
    end
    if ((state == ENG_SHIFT) && (bit_cnt == '0)) sample <= {miso_sr, miso};
  end

  a_mosi_quiet : assert property (@(posedge clk) disable iff (!resetn)
    n_cs |-> !mosi);

endmodule

/* test/adc_spi_model.sv */
module adc_spi_model (
  input  logic clk,
  input  logic n_cs,
  input  logic mosi,
  output logic miso
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int SW = adc_ctrl_pkg::SAMPLE_W;

  adc_ctrl_pkg::sample_t rx_sr;   // Request bits of the current frame
  adc_ctrl_pkg::sample_t tx_word; // Answer to the previous request
  int                    bit_idx; // Bits seen in the current frame

  // Decodes an on-the-fly request, anything else gets a zero answer
  function automatic adc_ctrl_pkg::sample_t answer(input adc_ctrl_pkg::sample_t req);
    adc_ctrl_pkg::chan_t ch;
    ch = req[SW-3 -: 3];
    if (req[SW-1 -: 2] != 2'b10) return '0;
    return 16'hA000 | {5'd0, ch, 8'h00} | (16'(ch) * 16'h0011);
  endfunction

  initial begin
    miso    = 1'b0;
    rx_sr   = '0;
    tx_word = '0;
    bit_idx = 0;
  end

  // Everything moves on the falling edge, the controller samples on the rising one
  always @(negedge clk) begin
    if (!n_cs) begin
      if (bit_idx < SW) begin
        rx_sr   = {rx_sr[SW-2:0], mosi};  // MSB first
        miso    = tx_word[SW-1-bit_idx];
        bit_idx = bit_idx + 1;
      end
    end else begin
      if (bit_idx == SW) tx_word = answer(rx_sr); // Full frame seen, answer next frame
      bit_idx = 0; // Cut frames after a halt are dropped
      miso    = 1'b0;
    end
  end

endmodule

/* test/tb_ads_adc_ctrl.sv */
module tb_ads_adc_ctrl;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_ROWS        = 6;
  localparam int WORDS           = adc_ctrl_pkg::NUM_CH / 2;
  localparam int ROW_LIMIT       = adc_ctrl_pkg::READ_FRAMES * 200 + 1000; // Cycles per row
  localparam int SETTLE_CYCLES   = 60;  // Quiet time before the end-of-row checks
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 2 * ROW_LIMIT;

  typedef adc_ctrl_pkg::data_word_t [WORDS-1:0] word_set_t;

  typedef struct packed {
    logic                               do_reset;
    logic [2:0]                         n_cmds;
    adc_ctrl_pkg::cmd_word_u [3:0]      cmds;
    logic                               full;     // data_buf_full for the whole row
    logic [7:0]                         trig_at;  // Cycle of the trigger pulse or 0 for none
    logic                               wait_exp; // waiting_for_trig at the pulse
    logic [2:0]                         n_words;
    word_set_t                          words;
    adc_ctrl_pkg::err_flags_t           flags;
  } row_t;

  logic                     clk;
  logic                     resetn;
  adc_ctrl_pkg::cmd_word_u  cmd_word;
  logic                     cmd_buf_empty;
  logic                     cmd_word_rd_en;
  adc_ctrl_pkg::data_word_t data_word;
  logic                     data_word_wr_en;
  logic                     data_buf_full;
  logic                     trigger;
  logic                     waiting_for_trig;
  adc_ctrl_pkg::err_flags_t flags;
  logic                     n_cs;
  logic                     mosi;
  logic                     miso;

  adc_ctrl_pkg::cmd_word_u  cmd_q[$];  // Command buffer contents
  adc_ctrl_pkg::data_word_t got_q[$];  // Data words written by the DUT
  logic                     pop_pending;
  row_t                     rows [NUM_ROWS];
  integer                   seed = 96;
  int                       errors;
  int                       failed_rows;

  ads_adc_ctrl #(.ADS_MODEL_ID(8)) UUT (
    .clk, .resetn, .cmd_word, .cmd_buf_empty, .cmd_word_rd_en, .data_word, .data_word_wr_en,
    .data_buf_full, .trigger, .waiting_for_trig, .flags, .n_cs, .mosi, .miso
  );

  adc_spi_model u_adc (.clk, .n_cs, .mosi, .miso);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // A word read in one cycle is gone from the command buffer in the next
  always @(negedge clk) pop_pending = resetn && cmd_word_rd_en;

  always @(posedge clk) begin
    #2;
    if (pop_pending && (cmd_q.size() != 0)) void'(cmd_q.pop_front());
    cmd_buf_empty = (cmd_q.size() == 0);
    if (cmd_buf_empty) cmd_word = '0;
    else cmd_word = cmd_q[0];
  end

  always @(negedge clk) begin
    if (resetn && data_word_wr_en) got_q.push_back(data_word); // Data buffer side
  end

  // A000 plus the channel in bits 10:8 plus the channel times 0x11
  function automatic adc_ctrl_pkg::sample_t expected_sample(input adc_ctrl_pkg::chan_t ch);
    return 16'hA000 | {5'd0, ch, 8'h00} | (16'(ch) * 16'h0011);
  endfunction

  function automatic word_set_t expected_words(input adc_ctrl_pkg::sample_order_t ord);
    word_set_t w;
    for (int k = 0; k < WORDS; k++) begin
      w[k].first  = expected_sample(ord[2*k]);   // Earlier slot in the low half
      w[k].second = expected_sample(ord[2*k+1]);
    end
    return w;
  endfunction

  function automatic adc_ctrl_pkg::cmd_word_u wait_cmd(input adc_ctrl_pkg::cmd_kind_e kind,
                                                       input logic trig, input logic cont,
                                                       input int delay);
    adc_ctrl_pkg::cmd_word_u c;
    c                 = '0;
    c.wait_view.kind  = kind;
    c.wait_view.trig  = trig;
    c.wait_view.cont  = cont;
    c.wait_view.delay = adc_ctrl_pkg::DELAY_W'(delay);
    return c;
  endfunction

  function automatic adc_ctrl_pkg::cmd_word_u order_cmd(input adc_ctrl_pkg::sample_order_t ord);
    adc_ctrl_pkg::cmd_word_u c;
    c                  = '0;
    c.order_view.kind  = adc_ctrl_pkg::SET_ORDER;
    c.order_view.order = ord;
    return c;
  endfunction

  // Fisher-Yates over the identity order
  task automatic shuffle_order(output adc_ctrl_pkg::sample_order_t ord);
    adc_ctrl_pkg::chan_t tmp;
    int                  j;
    for (int i = 0; i < adc_ctrl_pkg::NUM_CH; i++) ord[i] = adc_ctrl_pkg::chan_t'(i);
    for (int i = adc_ctrl_pkg::NUM_CH - 1; i > 0; i--) begin
      j      = $unsigned($random(seed)) % (i + 1);
      tmp    = ord[i];
      ord[i] = ord[j];
      ord[j] = tmp;
    end
  endtask

  task automatic build_table();
    adc_ctrl_pkg::sample_order_t ident;
    adc_ctrl_pkg::sample_order_t perm;
    for (int i = 0; i < adc_ctrl_pkg::NUM_CH; i++) ident[i] = adc_ctrl_pkg::chan_t'(i);
    shuffle_order(perm);
    for (int i = 0; i < NUM_ROWS; i++) rows[i] = '0;
    // Default order read whose delay may outlast the read
    rows[0].do_reset = 1'b1;
    rows[0].n_cmds   = 1;
    rows[0].cmds[0]  = wait_cmd(adc_ctrl_pkg::ADC_READ, 1'b0, 1'b0,
                                $unsigned($random(seed)) % 800);
    rows[0].n_words  = WORDS;
    rows[0].words    = expected_words(ident);
    // Trigger while idle
    rows[1].do_reset         = 1'b1;
    rows[1].trig_at          = 10;
    rows[1].flags.unexp_trig = 1'b1;
    // Read expecting a follow-up that never comes
    rows[2].do_reset                = 1'b1;
    rows[2].n_cmds                  = 1;
    rows[2].cmds[0]                 = wait_cmd(adc_ctrl_pkg::ADC_READ, 1'b0, 1'b1, 0);
    rows[2].n_words                 = WORDS;
    rows[2].words                   = expected_words(ident);
    rows[2].flags.cmd_buf_underflow = 1'b1;
    // Read into a full data buffer
    rows[3].do_reset                = 1'b1;
    rows[3].n_cmds                  = 1;
    rows[3].cmds[0]                 = wait_cmd(adc_ctrl_pkg::ADC_READ, 1'b0, 1'b0, 0);
    rows[3].full                    = 1'b1;
    rows[3].flags.data_buf_overflow = 1'b1;
    // Trigger wait, cancelled delay, then a read
    rows[4].do_reset = 1'b1;
    rows[4].n_cmds   = 4;
    rows[4].cmds[0]  = wait_cmd(adc_ctrl_pkg::NO_OP, 1'b1, 1'b0, 0);
    rows[4].cmds[1]  = wait_cmd(adc_ctrl_pkg::NO_OP, 1'b0, 1'b0,
                                ROW_LIMIT + ($unsigned($random(seed)) % 1000)); // Outlasts the row unless cancelled
    rows[4].cmds[2]  = wait_cmd(adc_ctrl_pkg::CANCEL, 1'b0, 1'b0, 0);
    rows[4].cmds[3]  = wait_cmd(adc_ctrl_pkg::ADC_READ, 1'b0, 1'b0, 0);
    rows[4].trig_at  = 20;
    rows[4].wait_exp = 1'b1;
    rows[4].n_words  = WORDS;
    rows[4].words    = expected_words(ident);
    // Shuffled order running on from the previous row
    rows[5].n_cmds  = 2;
    rows[5].cmds[0] = order_cmd(perm);
    rows[5].cmds[1] = wait_cmd(adc_ctrl_pkg::ADC_READ, 1'b0, 1'b0, 0);
    rows[5].n_words = WORDS;
    rows[5].words   = expected_words(perm);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_data(input int idx, input adc_ctrl_pkg::data_word_t got,
                            input adc_ctrl_pkg::data_word_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch data_word[%0d]: got 0x%h, expected 0x%h", idx, got, exp);
    end
  endtask

  task automatic check_flags(input adc_ctrl_pkg::err_flags_t got,
                             input adc_ctrl_pkg::err_flags_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch flags: got 0x%h, expected 0x%h", got, exp);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    cmd_q.delete();
    #1;
    resetn        = 1'b0;
    trigger       = 1'b0;
    data_buf_full = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    resetn = 1'b1;
    @(negedge clk);
    check_bit("n_cs", n_cs, 1'b1);  // Idle values right after reset
    check_bit("mosi", mosi, 1'b0);
    check_bit("cmd_word_rd_en", cmd_word_rd_en, 1'b0);
    check_bit("data_word_wr_en", data_word_wr_en, 1'b0);
    check_bit("waiting_for_trig", waiting_for_trig, 1'b0);
    check_flags(flags, '0);
  endtask

  function automatic logic row_finished(input row_t row, input int cyc);
    return (got_q.size() >= row.n_words) && (cyc > row.trig_at)
           && ((row.flags == '0) || (flags != '0));
  endfunction

  task automatic run_row(input int r);
    row_t row;
    int   cyc;
    int   errs_before;
    row         = rows[r];
    errs_before = errors;
    if (row.do_reset) apply_reset();
    @(posedge clk);
    #1;
    got_q.delete();
    for (int i = 0; i < row.n_cmds; i++) cmd_q.push_back(row.cmds[i]); // Seen at +2
    #1;
    data_buf_full = row.full;
    cyc = 0;
    while ((cyc < ROW_LIMIT) && !row_finished(row, cyc)) begin
      @(posedge clk);
      #2;
      cyc++;
      trigger = (row.trig_at != 0) && (cyc == row.trig_at); // One-cycle pulse
      if (trigger) check_bit("waiting_for_trig", waiting_for_trig, row.wait_exp);
    end
    trigger = 1'b0;
    if (cyc >= ROW_LIMIT) begin
      errors++;
      $display("Row %0d did not finish within %0d cycles", r, ROW_LIMIT);
    end
    if (row.flags != '0) begin
      #1;
      cmd_q.push_back(wait_cmd(adc_ctrl_pkg::ADC_READ, 1'b0, 1'b0, 0)); // Must stay unread
    end
    repeat (SETTLE_CYCLES) @(posedge clk); // Room for stray words
    @(negedge clk);
    if (got_q.size() != row.n_words) begin
      errors++;
      $display("Row %0d expected %0d data words but %0d were written",
               r, row.n_words, got_q.size());
    end
    for (int i = 0; (i < row.n_words) && (i < got_q.size()); i++)
      check_data(i, got_q[i], row.words[i]);
    check_flags(flags, row.flags);
    if ((row.flags != '0) && (cmd_q.size() != 1)) begin
      errors++;
      $display("Row %0d: the controller read a command after it halted", r);
    end
    check_bit("n_cs", n_cs, 1'b1);
    check_bit("waiting_for_trig", waiting_for_trig, 1'b0);
    if (errors != errs_before) failed_rows++;
    $display("Row %0d: %s", r, (errors == errs_before) ? "pass" : "FAIL");
  endtask

  initial begin
    clk           = 1'b0;
    resetn        = 1'b0;
    cmd_word      = '0;
    cmd_buf_empty = 1'b1;
    data_buf_full = 1'b0;
    trigger       = 1'b0;
    pop_pending   = 1'b0;
    errors        = 0;
    failed_rows   = 0;
    build_table();
    for (int r = 0; r < NUM_ROWS; r++) run_row(r);
    $display("Rows: %0d, failed rows: %0d, errors: %0d", NUM_ROWS, failed_rows, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog with a generous bound on all rows
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule
